/* logic/mipsPkg.sv */
package mipsPkg;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////

    // Primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;

    // R-type funct field
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnBreak = 6'h0d;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    // All zeros means a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       useImm;
        aluOp_t     aluOp;
        logic [4:0] dest;
        logic       isHalt;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } ifId_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
    } idEx_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
    } exMem_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] wbValue;
    } memWb_t;

    // Producer info seen by the hazard check
    typedef struct packed {
        logic       regWrite;
        logic [4:0] dest;
    } hazardTap_t;

    ////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apbRsp_t;

    // Host address map
    localparam logic [11:0] imemBase   = 12'h000;
    localparam logic [11:0] ctrlAddr   = 12'h100;
    localparam logic [11:0] statusAddr = 12'h104;
    localparam logic [11:0] regBase    = 12'h200;
    localparam logic [11:0] dmemBase   = 12'h400;

endpackage

/* logic/pipeReg.sv */
`timescale 1ns/100ps

module pipeReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t din,
    output payload_t dout
);

    // Bubble wins over hold so a squash is never lost in a stall
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            dout <= '0;
        end else if (!hold) begin
            dout <= din;
        end
    end

endmodule

/* logic/pipeControl.sv */
`timescale 1ns/100ps

module pipeControl (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         instr,
    input  logic [31:0]         decodePc,
    input  logic [31:0]         rsValue,
    input  logic [31:0]         rtValue,
    input  mipsPkg::hazardTap_t exTap,
    input  mipsPkg::hazardTap_t memTap,
    input  logic                wbHalt,
    input  logic                startPulse,
    output mipsPkg::ctrl_t      decodeCtrl,
    output logic                pcHold,
    output logic                ifIdHold,
    output logic                idExBubble,
    output logic                ifIdBubble,
    output logic                redirect,
    output logic [31:0]         redirectPc,
    output logic                running,
    output logic                halted
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] branchOffset;
    logic        isBeq;
    logic        isJr;
    logic        isBreak;
    logic        exHit;
    logic        memHit;
    logic        stall;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    // Word offset, sign extended
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    always_comb begin
        decodeCtrl = '0;
        case (opcode)
            mipsPkg::opRtype: begin
                decodeCtrl.dest = rd;
                case (funct)
                    mipsPkg::fnAddu: begin
                        decodeCtrl.regWrite = 1'b1;
                        decodeCtrl.aluOp    = mipsPkg::aluAdd;
                    end
                    mipsPkg::fnSubu: begin
                        decodeCtrl.regWrite = 1'b1;
                        decodeCtrl.aluOp    = mipsPkg::aluSub;
                    end
                    mipsPkg::fnAnd: begin
                        decodeCtrl.regWrite = 1'b1;
                        decodeCtrl.aluOp    = mipsPkg::aluAnd;
                    end
                    mipsPkg::fnOr: begin
                        decodeCtrl.regWrite = 1'b1;
                        decodeCtrl.aluOp    = mipsPkg::aluOr;
                    end
                    mipsPkg::fnSlt: begin
                        decodeCtrl.regWrite = 1'b1;
                        decodeCtrl.aluOp    = mipsPkg::aluSlt;
                    end
                    mipsPkg::fnBreak: decodeCtrl.isHalt = 1'b1;
                    // jr and unknown functs write nothing
                    default: decodeCtrl.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddiu: begin
                decodeCtrl.regWrite = 1'b1;
                decodeCtrl.useImm   = 1'b1;
                decodeCtrl.dest     = rt;
            end
            mipsPkg::opLw: begin
                decodeCtrl.regWrite = 1'b1;
                decodeCtrl.memRead  = 1'b1;
                decodeCtrl.useImm   = 1'b1;
                decodeCtrl.dest     = rt;
            end
            mipsPkg::opSw: begin
                decodeCtrl.memWrite = 1'b1;
                decodeCtrl.useImm   = 1'b1;
            end
            // beq only redirects
            default: decodeCtrl = '0;
        endcase
    end

    assign isBeq   = (opcode == mipsPkg::opBeq);
    assign isJr    = (opcode == mipsPkg::opRtype) && (funct == mipsPkg::fnJr);
    assign isBreak = (opcode == mipsPkg::opRtype) && (funct == mipsPkg::fnBreak);

    ////////////////////////////////////////
    // Hazards and redirect
    ////////////////////////////////////////

    // One rule covers ALU, load, branch and jr consumers
    // Writeback producers are covered by the write-through register file
    assign exHit = exTap.regWrite &&
        (((rs != 5'd0) && (rs == exTap.dest)) || ((rt != 5'd0) && (rt == exTap.dest)));
    assign memHit = memTap.regWrite &&
        (((rs != 5'd0) && (rs == memTap.dest)) || ((rt != 5'd0) && (rt == memTap.dest)));
    assign stall = exHit || memHit;

    // Operands are final once the stall is gone
    assign redirect   = running && !stall && ((isBeq && (rsValue == rtValue)) || isJr);
    assign redirectPc = isJr ? rsValue : decodePc + 32'd4 + branchOffset;

    // Break parks fetch so nothing past it issues
    assign pcHold     = !running || stall || isBreak;
    assign ifIdHold   = stall || isBreak;
    assign idExBubble = !running || stall;
    assign ifIdBubble = !running || redirect;

    ////////////////////////////////////////
    // Run and halt state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (startPulse) begin
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (wbHalt && running) begin
            // Break has retired
            running <= 1'b0;
            halted  <= 1'b1;
        end
    end

endmodule

/* logic/fetchUnit.sv */
`timescale 1ns/100ps

module fetchUnit #(
    parameter int imemWords = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pcHold,
    input  logic                         redirect,
    input  logic [31:0]                  redirectPc,
    input  logic                         startPulse,
    input  logic                         imemWrite,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  logic [31:0]                  imemData,
    output logic [31:0]                  instr,
    output logic [31:0]                  pc
);

    localparam int addrBits = $clog2(imemWords);

    logic [31:0] imem [imemWords];

    // Host load port
    always_ff @(posedge clk) begin
        if (imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    // Start beats redirect, redirect beats hold
    always_ff @(posedge clk) begin
        if (rst || startPulse) begin
            pc <= 32'd0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!pcHold) begin
            pc <= pc + 32'd4;
        end
    end

    // Asynchronous read, word addressed
    assign instr = imem[pc[2 +: addrBits]];

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  logic [4:0]     rsAddr,
    input  logic [4:0]     rtAddr,
    output logic [31:0]    rsValue,
    output logic [31:0]    rtValue,
    input  mipsPkg::ctrl_t wbCtrl,
    input  logic [31:0]    wbValue,
    input  logic [4:0]     hostRegAddr,
    output logic [31:0]    hostRegData
);

    logic [31:0] regs [32];
    logic        wrEn;

    // r0 is never written so it stays zero after reset
    assign wrEn = wbCtrl.regWrite && (wbCtrl.dest != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn) begin
            regs[wbCtrl.dest] <= wbValue;
        end
    end

    // Write-through bypass on every read port
    assign rsValue     = (wrEn && (rsAddr == wbCtrl.dest)) ? wbValue : regs[rsAddr];
    assign rtValue     = (wrEn && (rtAddr == wbCtrl.dest)) ? wbValue : regs[rtAddr];
    assign hostRegData = (wrEn && (hostRegAddr == wbCtrl.dest)) ? wbValue : regs[hostRegAddr];

endmodule

/* logic/aluExecute.sv */
`timescale 1ns/100ps

module aluExecute (
    input  mipsPkg::idEx_t  idEx,
    output mipsPkg::exMem_t exOut
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] result;

    assign opA = idEx.rsVal;

    // Immediate for addiu and the load/store address
    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            mipsPkg::aluAdd: result = opA + opB;
            mipsPkg::aluSub: result = opA - opB;
            mipsPkg::aluAnd: result = opA & opB;
            mipsPkg::aluOr:  result = opA | opB;
            // Signed compare
            mipsPkg::aluSlt: result = {31'd0, $signed(opA) < $signed(opB)};
            default:         result = 32'd0;
        endcase
    end

    always_comb begin
        exOut.ctrl      = idEx.ctrl;
        exOut.aluResult = result;
        // rt is the store source
        exOut.storeData = idEx.rtVal;
    end

endmodule

/* logic/dataMemory.sv */
`timescale 1ns/100ps

module dataMemory #(
    parameter int dmemWords = 64
) (
    input  logic                         clk,
    input  mipsPkg::exMem_t              exMem,
    output mipsPkg::memWb_t              memOut,
    input  logic [$clog2(dmemWords)-1:0] hostDmemAddr,
    output logic [31:0]                  hostDmemData
);

    localparam int addrBits = $clog2(dmemWords);

    logic [31:0]         dmem [dmemWords];
    logic [addrBits-1:0] wordAddr;

    // Byte address to word index
    assign wordAddr = exMem.aluResult[2 +: addrBits];

    always_ff @(posedge clk) begin
        if (exMem.ctrl.memWrite) begin
            dmem[wordAddr] <= exMem.storeData;
        end
    end

    always_comb begin
        memOut.ctrl    = exMem.ctrl;
        memOut.wbValue = exMem.ctrl.memRead ? dmem[wordAddr] : exMem.aluResult;
    end

    assign hostDmemData = dmem[hostDmemAddr];

endmodule

/* logic/apbHostPort.sv */
`timescale 1ns/100ps

module apbHostPort #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mipsPkg::apbReq_t             apbReq,
    output mipsPkg::apbRsp_t             apbRsp,
    output logic                         imemWrite,
    output logic [$clog2(imemWords)-1:0] imemAddr,
    output logic [31:0]                  imemData,
    output logic                         startPulse,
    output logic [4:0]                   hostRegAddr,
    output logic [$clog2(dmemWords)-1:0] hostDmemAddr,
    input  logic [31:0]                  hostRegData,
    input  logic [31:0]                  hostDmemData,
    input  logic                         running,
    input  logic                         halted
);

    logic        setupPhase;
    logic        accessWrite;
    logic [3:0]  window;
    logic [31:0] readMux;
    logic [31:0] prdataReg;

    assign setupPhase  = apbReq.psel && !apbReq.penable;
    assign accessWrite = apbReq.psel && apbReq.penable && apbReq.pwrite;

    // Each region is a 256 byte window
    assign window = apbReq.paddr[11:8];

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    assign imemWrite = accessWrite && (window == mipsPkg::imemBase[11:8]);
    assign imemAddr  = apbReq.paddr[2 +: $clog2(imemWords)];
    assign imemData  = apbReq.pwdata;

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    assign hostRegAddr  = apbReq.paddr[6:2];
    assign hostDmemAddr = apbReq.paddr[2 +: $clog2(dmemWords)];

    always_comb begin
        readMux = 32'd0;
        if (apbReq.paddr == mipsPkg::statusAddr) begin
            readMux = {30'd0, halted, running};
        end else if ((window == mipsPkg::regBase[11:8]) && !apbReq.paddr[7]) begin
            // Only 32 registers, upper half unmapped
            readMux = hostRegData;
        end else if (window == mipsPkg::dmemBase[11:8]) begin
            readMux = hostDmemData;
        end
    end

    // Sample in setup so data is there for the access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            startPulse <= 1'b0;
            prdataReg  <= 32'd0;
        end else begin
            startPulse <= accessWrite && (apbReq.paddr == mipsPkg::ctrlAddr) &&
                          apbReq.pwdata[0];
            if (setupPhase && !apbReq.pwrite) begin
                prdataReg <= readMux;
            end
        end
    end

    // Zero wait states
    assign apbRsp.prdata = prdataReg;
    assign apbRsp.pready = 1'b1;

endmodule

/* logic/mipsCoreTop.sv */
`timescale 1ns/100ps

module mipsCoreTop #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::apbReq_t apbReq,
    output mipsPkg::apbRsp_t apbRsp
);

    // Host side
    logic                         imemWrite;
    logic [$clog2(imemWords)-1:0] imemAddr;
    logic [31:0]                  imemData;
    logic                         startPulse;
    logic [4:0]                   hostRegAddr;
    logic [$clog2(dmemWords)-1:0] hostDmemAddr;
    logic [31:0]                  hostRegData;
    logic [31:0]                  hostDmemData;

    // Control
    logic                pcHold;
    logic                ifIdHold;
    logic                idExBubble;
    logic                ifIdBubble;
    logic                redirect;
    logic [31:0]         redirectPc;
    logic                running;
    logic                halted;
    mipsPkg::ctrl_t      decodeCtrl;
    mipsPkg::hazardTap_t exTap;
    mipsPkg::hazardTap_t memTap;

    // Datapath
    logic [31:0]     rsValue;
    logic [31:0]     rtValue;
    mipsPkg::ifId_t  ifIdIn;
    mipsPkg::ifId_t  ifIdOut;
    mipsPkg::idEx_t  idExIn;
    mipsPkg::idEx_t  idExOut;
    mipsPkg::exMem_t exMemIn;
    mipsPkg::exMem_t exMemOut;
    mipsPkg::memWb_t memWbIn;
    mipsPkg::memWb_t memWbOut;

    ////////////////////////////////////////
    // Stage payload wiring
    ////////////////////////////////////////

    assign idExIn = '{
        ctrl:  decodeCtrl,
        rsVal: rsValue,
        rtVal: rtValue,
        imm:   {{16{ifIdOut.instr[15]}}, ifIdOut.instr[15:0]}
    };

    // Producers in execute and memory
    assign exTap  = '{regWrite: idExOut.ctrl.regWrite, dest: idExOut.ctrl.dest};
    assign memTap = '{regWrite: exMemOut.ctrl.regWrite, dest: exMemOut.ctrl.dest};

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    apbHostPort #(
        .imemWords(imemWords),
        .dmemWords(dmemWords)
    ) i_apbHostPort (
        .clk(clk),
        .rst(rst),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .imemWrite(imemWrite),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .startPulse(startPulse),
        .hostRegAddr(hostRegAddr),
        .hostDmemAddr(hostDmemAddr),
        .hostRegData(hostRegData),
        .hostDmemData(hostDmemData),
        .running(running),
        .halted(halted)
    );

    pipeControl i_pipeControl (
        .clk(clk),
        .rst(rst),
        .instr(ifIdOut.instr),
        .decodePc(ifIdOut.pc),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .exTap(exTap),
        .memTap(memTap),
        .wbHalt(memWbOut.ctrl.isHalt),
        .startPulse(startPulse),
        .decodeCtrl(decodeCtrl),
        .pcHold(pcHold),
        .ifIdHold(ifIdHold),
        .idExBubble(idExBubble),
        .ifIdBubble(ifIdBubble),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .running(running),
        .halted(halted)
    );

    fetchUnit #(.imemWords(imemWords)) i_fetchUnit (
        .clk(clk),
        .rst(rst),
        .pcHold(pcHold),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .startPulse(startPulse),
        .imemWrite(imemWrite),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .instr(ifIdIn.instr),
        .pc(ifIdIn.pc)
    );

    pipeReg #(.payload_t(mipsPkg::ifId_t)) i_ifIdReg (
        .clk(clk),
        .rst(rst),
        .hold(ifIdHold),
        .bubble(ifIdBubble),
        .din(ifIdIn),
        .dout(ifIdOut)
    );

    regFile i_regFile (
        .clk(clk),
        .rst(rst),
        .rsAddr(ifIdOut.instr[25:21]),
        .rtAddr(ifIdOut.instr[20:16]),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .wbCtrl(memWbOut.ctrl),
        .wbValue(memWbOut.wbValue),
        .hostRegAddr(hostRegAddr),
        .hostRegData(hostRegData)
    );

    pipeReg #(.payload_t(mipsPkg::idEx_t)) i_idExReg (
        .clk(clk),
        .rst(rst),
        .hold(1'b0),
        .bubble(idExBubble),
        .din(idExIn),
        .dout(idExOut)
    );

    aluExecute i_aluExecute (
        .idEx(idExOut),
        .exOut(exMemIn)
    );

    // Later stages drain to bubbles once stopped
    pipeReg #(.payload_t(mipsPkg::exMem_t)) i_exMemReg (
        .clk(clk),
        .rst(rst),
        .hold(1'b0),
        .bubble(!running),
        .din(exMemIn),
        .dout(exMemOut)
    );

    dataMemory #(.dmemWords(dmemWords)) i_dataMemory (
        .clk(clk),
        .exMem(exMemOut),
        .memOut(memWbIn),
        .hostDmemAddr(hostDmemAddr),
        .hostDmemData(hostDmemData)
    );

    pipeReg #(.payload_t(mipsPkg::memWb_t)) i_memWbReg (
        .clk(clk),
        .rst(rst),
        .hold(1'b0),
        .bubble(!running),
        .din(memWbIn),
        .dout(memWbOut)
    );

endmodule

/* sim/mipsCoreTb.sv */
`timescale 1ns/100ps

module mipsCoreTb;

    localparam int imemWords = 64;
    localparam int dmemWords = 64;
    localparam int numProgs  = 4;
    localparam int maxInstr  = 16;

    // Host address map
    localparam logic [11:0] imemWindow = 12'h000;
    localparam logic [11:0] ctrlReg    = 12'h100;
    localparam logic [11:0] statusReg  = 12'h104;
    localparam logic [11:0] regWindow  = 12'h200;
    localparam logic [11:0] memWindow  = 12'h400;

    // MIPS encodings
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [31:0] breakWord = {26'd0, 6'h0d};

    // At most two stall cycles per instruction, plus pipeline drain
    localparam int runCycles      = maxInstr * 3 + 50;
    // Reset, program load, status polls and readback
    localparam int hostCycles     = maxInstr * 3 + 100;
    localparam int watchdogCycles = numProgs * (2 * runCycles + hostCycles);

    // One expected register or data word
    typedef struct packed {
        logic [3:0]  prog;
        logic        isMem;
        logic [5:0]  index;
        logic [31:0] value;
    } expect_t;

    logic              clk = 1'b0;
    logic              rst;
    mipsPkg::apbReq_t  apbReq;
    mipsPkg::apbRsp_t  apbRsp;

    logic [31:0] progCode [numProgs][maxInstr];
    int          progLen [numProgs];
    expect_t     expectTable [$];
    integer      seed;
    int          errorCount;

    mipsCoreTop #(
        .imemWords(imemWords),
        .dmemWords(dmemWords)
    ) i_mipsCoreTop (
        .clk(clk),
        .rst(rst),
        .apbReq(apbReq),
        .apbRsp(apbRsp)
    );

    // 4 ns period
    always #2 clk = ~clk;

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: programs did not complete within %0d cycles", watchdogCycles);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////
    // Encoding and reference arithmetic
    ////////////////////////////////////////

    function automatic logic [31:0] encR(int rs, int rt, int rd, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] signExt(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Word offset relative to the slot after the branch
    function automatic logic [15:0] branchImm(int from, int to);
        return 16'(to - from - 1);
    endfunction

    // Negative operand is smaller when the signs differ
    function automatic logic [31:0] lessThan(logic [31:0] x, logic [31:0] y);
        if (x[31] != y[31]) begin
            return x[31] ? 32'd1 : 32'd0;
        end
        return (x < y) ? 32'd1 : 32'd0;
    endfunction

    ////////////////////////////////////////
    // Checks and host bus
    ////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount = errorCount + 1;
            $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the access
    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b1;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        @(negedge clk);
        apbReq.penable = 1'b1;
        checkValue("pready", {31'd0, apbRsp.pready}, 32'd1);
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
        apbReq.paddr   = addr;
        @(negedge clk);
        apbReq.penable = 1'b1;
        checkValue("pready", {31'd0, apbRsp.pready}, 32'd1);
        // Read data is registered at setup, stable all through access
        data = apbRsp.prdata;
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    ////////////////////////////////////////
    // Program table
    ////////////////////////////////////////

    task automatic emit(input int p, input logic [31:0] word);
        if (progLen[p] >= maxInstr) begin
            $display("Program %0d does not fit in %0d instruction slots", p, maxInstr);
            $display("Regression failed");
            $fatal(1, "Program table overflow");
        end else begin
            progCode[p][progLen[p]] = word;
            progLen[p] = progLen[p] + 1;
        end
    endtask

    task automatic addExpect(input int p, input logic mem, input int idx,
                             input logic [31:0] val);
        expect_t e;
        e.prog  = 4'(p);
        e.isMem = mem;
        e.index = 6'(idx);
        e.value = val;
        expectTable.push_back(e);
    endtask

    task automatic buildPrograms();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        for (int p = 0; p < numProgs; p++) begin
            progLen[p] = 0;
            // Unused slots halt the core
            for (int i = 0; i < maxInstr; i++) begin
                progCode[p][i] = breakWord;
            end
        end

        // ALU ops on random operands, writes to r0 discarded
        immA = 16'($random(seed));
        immB = 16'($random(seed));
        immC = 16'($random(seed));
        a = signExt(immA);
        b = signExt(immB);
        emit(0, encI(opAddiu, 0, 1, immA));
        emit(0, encI(opAddiu, 0, 2, immB));
        emit(0, encR(1, 2, 3, fnAddu));
        emit(0, encR(1, 2, 4, fnSubu));
        emit(0, encR(1, 2, 5, fnAnd));
        emit(0, encR(1, 2, 6, fnOr));
        emit(0, encR(1, 2, 7, fnSlt));
        emit(0, encR(2, 1, 8, fnSlt));
        emit(0, encI(opAddiu, 1, 9, immC));
        emit(0, encI(opAddiu, 0, 0, 16'h0055));
        emit(0, encR(1, 2, 0, fnAddu));
        emit(0, breakWord);
        addExpect(0, 1'b0, 0, 32'd0);
        addExpect(0, 1'b0, 1, a);
        addExpect(0, 1'b0, 2, b);
        addExpect(0, 1'b0, 3, a + b);
        addExpect(0, 1'b0, 4, a - b);
        addExpect(0, 1'b0, 5, a & b);
        addExpect(0, 1'b0, 6, a | b);
        addExpect(0, 1'b0, 7, lessThan(a, b));
        addExpect(0, 1'b0, 8, lessThan(b, a));
        addExpect(0, 1'b0, 9, a + signExt(immC));

        // Dependency chains, back to back and one apart
        immA = 16'($random(seed));
        immB = 16'($random(seed));
        immC = 16'($random(seed));
        a = signExt(immA);
        b = a + signExt(immB);
        c = signExt(immC);
        emit(1, encI(opAddiu, 0, 1, immA));
        emit(1, encI(opAddiu, 1, 2, immB));
        emit(1, encI(opAddiu, 0, 3, immC));
        emit(1, encR(2, 0, 4, fnSubu));
        emit(1, encR(4, 1, 5, fnAddu));
        emit(1, encI(opAddiu, 0, 7, 16'd3));
        emit(1, encR(5, 3, 6, fnAddu));
        emit(1, breakWord);
        addExpect(1, 1'b0, 1, a);
        addExpect(1, 1'b0, 2, b);
        addExpect(1, 1'b0, 3, c);
        addExpect(1, 1'b0, 4, b);
        addExpect(1, 1'b0, 5, b + a);
        addExpect(1, 1'b0, 7, 32'd3);
        addExpect(1, 1'b0, 6, b + a + c);

        // Stores, then loads used right away
        immA = 16'($random(seed));
        immB = 16'($random(seed));
        a = signExt(immA);
        b = signExt(immB);
        emit(2, encI(opAddiu, 0, 1, immA));
        emit(2, encI(opAddiu, 0, 2, immB));
        emit(2, encI(opAddiu, 0, 10, 16'h0020));
        emit(2, encI(opSw, 10, 1, 16'd0));
        emit(2, encI(opSw, 10, 2, 16'd4));
        emit(2, encI(opLw, 10, 3, 16'd0));
        emit(2, encR(3, 3, 4, fnAddu));
        emit(2, encI(opLw, 10, 5, 16'd4));
        emit(2, encR(5, 1, 6, fnSubu));
        emit(2, encI(opSw, 10, 6, 16'd8));
        emit(2, breakWord);
        addExpect(2, 1'b0, 3, a);
        addExpect(2, 1'b0, 4, a + a);
        addExpect(2, 1'b0, 5, b);
        addExpect(2, 1'b0, 6, b - a);
        addExpect(2, 1'b1, 8, a);
        addExpect(2, 1'b1, 9, b);
        addExpect(2, 1'b1, 10, b - a);

        // beq not taken, beq taken, jr; r20 to r22 are wrong-path sentinels
        emit(3, encI(opAddiu, 0, 1, 16'd7));
        emit(3, encI(opAddiu, 0, 2, 16'd7));
        emit(3, encI(opAddiu, 0, 3, 16'd9));
        emit(3, encI(opBeq, 1, 3, branchImm(3, 5)));
        emit(3, encI(opAddiu, 0, 4, 16'd1));
        emit(3, encI(opBeq, 1, 2, branchImm(5, 7)));
        emit(3, encI(opAddiu, 0, 20, 16'h0bad));
        emit(3, encI(opAddiu, 0, 5, 16'd2));
        emit(3, encI(opAddiu, 0, 11, 16'(12 * 4)));
        emit(3, encR(11, 0, 0, fnJr));
        emit(3, encI(opAddiu, 0, 21, 16'h0bad));
        emit(3, encI(opAddiu, 0, 22, 16'h0bad));
        emit(3, encI(opAddiu, 0, 6, 16'd3));
        emit(3, breakWord);
        addExpect(3, 1'b0, 4, 32'd1);
        addExpect(3, 1'b0, 5, 32'd2);
        addExpect(3, 1'b0, 6, 32'd3);
        addExpect(3, 1'b0, 11, 32'd48);
        addExpect(3, 1'b0, 20, 32'd0);
        addExpect(3, 1'b0, 21, 32'd0);
        addExpect(3, 1'b0, 22, 32'd0);

        // r31 is only written by the slot planted past each break
        for (int p = 0; p < numProgs; p++) begin
            addExpect(p, 1'b0, 31, 32'd0);
        end
    endtask

    ////////////////////////////////////////
    // Program runs
    ////////////////////////////////////////

    task automatic loadProgram(input int p);
        for (int i = 0; i < maxInstr; i++) begin
            apbWrite(12'(imemWindow + i * 4), progCode[p][i]);
        end
    endtask

    task automatic startAndWait();
        logic [31:0] status;
        apbWrite(ctrlReg, 32'd1);
        // Start pulse is registered, running follows one cycle later
        @(negedge clk);
        status = 32'd0;
        while (status[1] !== 1'b1) begin
            apbRead(statusReg, status);
        end
        checkValue("status after break", status, 32'h0000_0002);
    endtask

    task automatic checkResults(input int p, input int run);
        expect_t     e;
        logic [31:0] data;
        foreach (expectTable[i]) begin
            e = expectTable[i];
            if (e.prog == 4'(p)) begin
                if (e.isMem) begin
                    apbRead(12'(memWindow + e.index * 4), data);
                    checkValue($sformatf("prog%0d run%0d dmem[%0d]", p, run, e.index),
                               data, e.value);
                end else begin
                    apbRead(12'(regWindow + e.index * 4), data);
                    checkValue($sformatf("prog%0d run%0d r%0d", p, run, e.index),
                               data, e.value);
                end
            end
        end
    endtask

    initial begin
        logic [31:0] status;
        rst        = 1'b1;
        apbReq     = '0;
        seed       = 73368;
        errorCount = 0;
        buildPrograms();

        for (int p = 0; p < numProgs; p++) begin
            // Fresh register file for each program
            applyReset();
            apbRead(statusReg, status);
            checkValue("status after reset", status, 32'h0000_0000);
            loadProgram(p);
            // Second start reruns from PC 0
            for (int run = 0; run < 2; run++) begin
                startAndWait();
                checkResults(p, run);
                if (run == 0) begin
                    // Reached only if the rerun resumes past the break
                    apbWrite(12'(imemWindow + progLen[p] * 4),
                             encI(opAddiu, 0, 31, 16'h0bad));
                end
            end
        end

        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* all.f */
logic/mipsPkg.sv
logic/pipeReg.sv
logic/pipeControl.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/aluExecute.sv
logic/dataMemory.sv
logic/apbHostPort.sv
logic/mipsCoreTop.sv
sim/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module mipsCoreTb -f all.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "Pass line missing from simulation output"
exit 1
